// ==== Makefile ====
VERILATOR = verilator
FLAGS     = --binary --timing --assert -j 0 --timescale 1ns/1ps
TOP       = tb_dec6502
RTL_TOP   = dec6502_top
FILELIST  = build.f
OBJ_DIR   = obj_dir
PASS_MSG  = === PASS ===

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@out=$$(./$(OBJ_DIR)/V$(TOP) 2>&1); echo "$$out"; \
	echo "$$out" | grep -qF -- "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only -Wall --timing --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// ==== build.f ====
+incdir+.
dec6502_pkg.sv
opcode_latch.sv
op_classifier.sv
step_sequencer.sv
control_out.sv
dec6502_top.sv
tb_dec6502.sv

// ==== control_out.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Registered control word, write strobes and done
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "dec6502_config.svh"

module control_out import dec6502_pkg::*; (
        input  logic       clk,
        input  logic       reset_n,
        input  seq_state_t state,
        input  plan_t      plan,
        input  byte_t      status_in,
        output ctrl_t      ctrl,
        output we_t        we,
        output sel_t       wb_sel,
        output logic       instruction_done,
        output logic       busy
);

        logic carry_bit;
        logic busy_q;

        always_comb begin
                case (plan.carry_src)
                        CARRY_ONE:    carry_bit = 1'b1;
                        CARRY_STATUS: carry_bit = status_in[`CARRY_BIT];
                        default:      carry_bit = 1'b0;
                endcase
        end

        always_ff @(posedge clk) begin
                if (!reset_n) begin
                        ctrl             <= '0;
                        wb_sel           <= SEL_ZERO;
                        we               <= '0;
                        instruction_done <= 1'b0;
                        busy_q           <= 1'b0;
                end else begin
                        if (state == ST_IDLE) begin
                                ctrl <= '0;     // Back to NONE once the instruction retires
                        end else begin
                                ctrl <= '{
                                        alu0_sel:      plan.alu0_sel,
                                        alu1_sel:      plan.alu1_sel,
                                        alu_op:        plan.alu_op,
                                        carry_in:      carry_bit,
                                        update_status: plan.wb_we.stat
                                };
                                wb_sel <= plan.wb_sel;
                        end
                        we <= (state == ST_WRITE) ? plan.wb_we : '0;
                        instruction_done <= (state == ST_WRITE && plan.op_class != CLASS_RMW) ||
                                            (state == ST_FINISH);
                        busy_q <= state != ST_IDLE;
                end
        end

        // Rises with SETUP, falls one cycle after the sequence ends
        assign busy = busy_q || (state != ST_IDLE);

endmodule

// ==== dec6502_config.svh ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Data width, carry index, addressing-mode columns
// and op-group codes of the 6502 decoder
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef DEC6502_CONFIG_SVH
`define DEC6502_CONFIG_SVH

`define REG_WIDTH 8
`define CARRY_BIT 0

`define AM_X_IND 3'b000        // (zp,X), or immediate for LDX/LDY
`define AM_IMPL  3'b010        // Immediate, accumulator or implied

// Op-group code is {opcode[7:5], opcode[1:0]}
`define GRP_ORA 5'b000_01
`define GRP_AND 5'b001_01
`define GRP_EOR 5'b010_01
`define GRP_ADC 5'b011_01
`define GRP_STA 5'b100_01
`define GRP_LDA 5'b101_01
`define GRP_ASL 5'b000_10
`define GRP_ROL 5'b001_10
`define GRP_LSR 5'b010_10
`define GRP_ROR 5'b011_10
`define GRP_STX 5'b100_10
`define GRP_LDX 5'b101_10
`define GRP_DEC 5'b110_10
`define GRP_INC 5'b111_10
`define GRP_STY 5'b100_00
`define GRP_LDY 5'b101_00
`define GRP_INY 5'b110_00
`define GRP_INX 5'b111_00

`endif

// ==== dec6502_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Decoder types: vectors, selector and state enums,
// write enables, instruction plan and control word
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "dec6502_config.svh"

package dec6502_pkg;

        typedef logic [`REG_WIDTH-1:0] byte_t;
        typedef logic [2:0]            addr_mode_t;   // Opcode bits 4..2

        typedef enum logic [2:0] {
                SEL_ACC,
                SEL_X,
                SEL_Y,
                SEL_MEM,
                SEL_IMM,
                SEL_ALU,
                SEL_ZERO,
                SEL_FF
        } sel_t;

        typedef enum logic [2:0] {
                ALU_NONE,
                ALU_OR,
                ALU_AND,
                ALU_XOR,
                ALU_SUM,
                ALU_SR
        } alu_op_t;

        // Shape of the cycle sequence
        typedef enum logic [1:0] {CLASS_ALU_REG, CLASS_MOVE, CLASS_RMW} op_class_t;

        typedef enum logic [1:0] {CARRY_ZERO, CARRY_ONE, CARRY_STATUS} carry_src_t;

        typedef struct packed {
                logic acc;
                logic x;
                logic y;
                logic dout;
                logic stat;
        } we_t;

        typedef struct packed {
                op_class_t  op_class;
                alu_op_t    alu_op;
                sel_t       alu0_sel;
                sel_t       alu1_sel;
                carry_src_t carry_src;
                sel_t       wb_sel;
                we_t        wb_we;
        } plan_t;

        typedef struct packed {
                sel_t    alu0_sel;
                sel_t    alu1_sel;
                alu_op_t alu_op;
                logic    carry_in;
                logic    update_status;
        } ctrl_t;

        typedef enum logic [2:0] {ST_IDLE, ST_SETUP, ST_WAIT_ALU, ST_WRITE, ST_FINISH} seq_state_t;

endpackage

// ==== dec6502_tests.txt ====
// opcode status alu_op alu0 alu1 cin upd we wb_sel rmw supported
// sel 0 ACC 1 X 2 Y 3 MEM 4 IMM 5 ALU 6 ZERO 7 FF, alu_op 0 NONE 1 OR 2 AND 3 XOR 4 SUM 5 SR
09 01 01 00 04 00 00 10 05 00 01  // ORA #imm
05 00 01 00 03 00 00 10 05 00 01  // ORA zp
29 FE 02 00 04 00 00 10 05 00 01  // AND #imm
2D 01 02 00 03 00 00 10 05 00 01  // AND abs
49 00 03 00 04 00 00 10 05 00 01  // EOR #imm
51 FF 03 00 03 00 00 10 05 00 01  // EOR (zp),Y
69 01 04 00 04 01 01 11 05 00 01  // ADC #imm, carry set
65 FE 04 00 03 00 01 11 05 00 01  // ADC zp, carry clear
6D FF 04 00 03 01 01 11 05 00 01  // ADC abs, carry set
0A 01 04 00 00 00 01 11 05 00 01  // ASL A
06 00 04 03 03 00 01 11 05 00 01  // ASL zp
2A 01 04 00 00 01 01 11 05 00 01  // ROL A, carry set
26 FE 04 03 03 00 01 11 05 00 01  // ROL zp, carry clear
4A 01 05 00 06 00 01 11 05 00 01  // LSR A
6A FF 05 00 06 01 01 11 05 00 01  // ROR A, carry set
6E 00 05 03 06 00 01 11 05 00 01  // ROR abs, carry clear
A9 00 00 06 06 00 00 10 04 00 01  // LDA #imm
A5 01 00 06 06 00 00 10 03 00 01  // LDA zp
A2 00 00 06 06 00 00 08 04 00 01  // LDX #imm
A0 00 00 06 06 00 00 04 04 00 01  // LDY #imm
A6 00 00 06 06 00 00 08 03 00 01  // LDX zp
AC 01 00 06 06 00 00 04 03 00 01  // LDY abs
85 00 00 06 06 00 00 02 00 00 01  // STA zp
86 01 00 06 06 00 00 02 01 00 01  // STX zp
84 00 00 06 06 00 00 02 02 00 01  // STY zp
E6 00 04 03 06 01 01 03 05 01 01  // INC zp
C6 01 04 03 07 00 00 02 05 01 01  // DEC zp
E8 00 04 01 06 01 01 09 05 00 01  // INX
C8 00 04 02 06 01 01 05 05 00 01  // INY
CA 01 04 01 07 00 00 08 05 00 01  // DEX
88 01 04 02 07 00 00 04 05 00 01  // DEY
C9 00 00 00 00 00 00 00 00 00 00  // CMP #imm
E9 01 00 00 00 00 00 00 00 00 00  // SBC #imm
00 00 00 00 00 00 00 00 00 00 00  // BRK
89 00 00 00 00 00 00 00 00 00 00  // STA #imm does not exist

// ==== dec6502_top.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// 6502 decoder and sequencer top level
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module dec6502_top import dec6502_pkg::*; (
        input  logic  clk,
        input  logic  reset_n,
        input  logic  instruction_ready,
        input  byte_t instruction_in,
        input  byte_t status_in,
        input  logic  alu_done,
        output ctrl_t ctrl,
        output we_t   we,
        output sel_t  wb_sel,
        output logic  instruction_done,
        output logic  busy
);

        logic       accept;
        logic       raw_supported;
        byte_t      opcode;
        sel_t       operand_sel;
        plan_t      plan;
        seq_state_t state;

        opcode_latch u_opcode_latch (
                .clk            (clk),
                .reset_n        (reset_n),
                .instruction_in (instruction_in),
                .accept         (accept),
                .opcode         (opcode),
                .operand_sel    (operand_sel)
        );

        op_classifier u_op_classifier (
                .opcode         (opcode),
                .operand_sel    (operand_sel),
                .instruction_in (instruction_in),
                .plan           (plan),
                .raw_supported  (raw_supported)
        );

        step_sequencer u_step_sequencer (
                .clk               (clk),
                .reset_n           (reset_n),
                .instruction_ready (instruction_ready),
                .raw_supported     (raw_supported),
                .op_class          (plan.op_class),
                .alu_done          (alu_done),
                .accept            (accept),
                .state             (state)
        );

        control_out u_control_out (
                .clk              (clk),
                .reset_n          (reset_n),
                .state            (state),
                .plan             (plan),
                .status_in        (status_in),
                .ctrl             (ctrl),
                .we               (we),
                .wb_sel           (wb_sel),
                .instruction_done (instruction_done),
                .busy             (busy)
        );

endmodule

// ==== op_classifier.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Opcode to instruction plan mapping, support check
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "dec6502_config.svh"

module op_classifier import dec6502_pkg::*; (
        input  byte_t opcode,
        input  sel_t  operand_sel,
        input  byte_t instruction_in,
        output plan_t plan,
        output logic  raw_supported
);

        function automatic logic is_supported(byte_t op);
                logic [4:0] grp;
                addr_mode_t mode;
                grp  = {op[7:5], op[1:0]};
                mode = op[4:2];
                case (grp)
                        `GRP_ORA, `GRP_AND, `GRP_EOR, `GRP_ADC, `GRP_LDA:
                                return 1'b1;
                        `GRP_STA:
                                return mode != `AM_IMPL;
                        `GRP_ASL, `GRP_ROL, `GRP_LSR, `GRP_ROR, `GRP_DEC:
                                return mode inside {3'b001, 3'b010, 3'b011, 3'b101, 3'b111};
                        `GRP_LDX, `GRP_LDY:
                                return mode inside {3'b000, 3'b001, 3'b011, 3'b101, 3'b111};
                        `GRP_INC:
                                return mode inside {3'b001, 3'b011, 3'b101, 3'b111};
                        `GRP_STX:
                                return mode inside {3'b001, 3'b011, 3'b101};
                        `GRP_STY:
                                return mode inside {3'b001, 3'b010, 3'b011, 3'b101};
                        `GRP_INX, `GRP_INY:
                                return mode == `AM_IMPL;
                        default:
                                return 1'b0;    // CMP, SBC, branches and the rest
                endcase
        endfunction

        function automatic plan_t plan_of(byte_t op, sel_t operand);
                plan_t      p;
                logic [4:0] grp;
                addr_mode_t mode;
                grp  = {op[7:5], op[1:0]};
                mode = op[4:2];
                // Default shape is ACC op operand, result back to ACC
                p.op_class  = CLASS_ALU_REG;
                p.alu_op    = ALU_NONE;
                p.alu0_sel  = SEL_ACC;
                p.alu1_sel  = operand;
                p.carry_src = CARRY_ZERO;
                p.wb_sel    = SEL_ALU;
                p.wb_we     = '0;
                if (!is_supported(op)) begin
                        p.op_class = CLASS_MOVE;
                end else begin
                        case (grp)
                                `GRP_ORA, `GRP_AND, `GRP_EOR: begin
                                        p.alu_op = (grp == `GRP_ORA) ? ALU_OR :
                                                   (grp == `GRP_AND) ? ALU_AND : ALU_XOR;
                                        p.wb_we.acc = 1'b1;
                                end
                                `GRP_ADC: begin
                                        p.alu_op     = ALU_SUM;
                                        p.carry_src  = CARRY_STATUS;
                                        p.wb_we.acc  = 1'b1;
                                        p.wb_we.stat = 1'b1;
                                end
                                `GRP_ASL, `GRP_ROL, `GRP_LSR, `GRP_ROR: begin
                                        // Bit 6 picks right shift, bit 5 the rotate
                                        p.alu_op     = op[6] ? ALU_SR : ALU_SUM;
                                        p.alu0_sel   = operand;
                                        p.alu1_sel   = op[6] ? SEL_ZERO : operand;
                                        p.carry_src  = op[5] ? CARRY_STATUS : CARRY_ZERO;
                                        p.wb_we.acc  = 1'b1;
                                        p.wb_we.stat = 1'b1;
                                end
                                `GRP_LDA, `GRP_LDX, `GRP_LDY: begin
                                        p.op_class  = CLASS_MOVE;
                                        p.wb_sel    = operand;
                                        p.wb_we.acc = grp == `GRP_LDA;
                                        p.wb_we.x   = grp == `GRP_LDX;
                                        p.wb_we.y   = grp == `GRP_LDY;
                                end
                                `GRP_STA, `GRP_STX: begin
                                        p.op_class   = CLASS_MOVE;
                                        p.wb_sel     = (grp == `GRP_STA) ? SEL_ACC : SEL_X;
                                        p.wb_we.dout = 1'b1;
                                end
                                `GRP_STY: begin
                                        if (mode == `AM_IMPL) begin     // DEY
                                                p.alu_op   = ALU_SUM;
                                                p.alu0_sel = operand;
                                                p.alu1_sel = SEL_FF;
                                                p.wb_we.y  = 1'b1;
                                        end else begin
                                                p.op_class   = CLASS_MOVE;
                                                p.wb_sel     = SEL_Y;
                                                p.wb_we.dout = 1'b1;
                                        end
                                end
                                `GRP_DEC: begin
                                        p.alu_op   = ALU_SUM;
                                        p.alu0_sel = operand;
                                        p.alu1_sel = SEL_FF;     // Add 0xFF to decrement
                                        if (mode == `AM_IMPL) begin     // DEX
                                                p.wb_we.x = 1'b1;
                                        end else begin
                                                p.op_class   = CLASS_RMW;
                                                p.wb_we.dout = 1'b1;
                                        end
                                end
                                `GRP_INC: begin
                                        p.op_class   = CLASS_RMW;
                                        p.alu_op     = ALU_SUM;
                                        p.alu0_sel   = operand;
                                        p.alu1_sel   = SEL_ZERO;
                                        p.carry_src  = CARRY_ONE;
                                        p.wb_we.dout = 1'b1;
                                        p.wb_we.stat = 1'b1;
                                end
                                default: begin                  // INX, INY
                                        p.alu_op     = ALU_SUM;
                                        p.alu0_sel   = operand;
                                        p.alu1_sel   = SEL_ZERO;
                                        p.carry_src  = CARRY_ONE;
                                        p.wb_we.x    = grp == `GRP_INX;
                                        p.wb_we.y    = grp == `GRP_INY;
                                        p.wb_we.stat = 1'b1;
                                end
                        endcase
                end
                if (p.op_class == CLASS_MOVE) begin
                        p.alu0_sel = SEL_ZERO;  // ALU sits idle on loads and stores
                        p.alu1_sel = SEL_ZERO;
                end
                return p;
        endfunction

        assign plan          = plan_of(opcode, operand_sel);
        assign raw_supported = is_supported(instruction_in);

endmodule

// ==== opcode_latch.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Opcode register with operand source resolution
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "dec6502_config.svh"

module opcode_latch import dec6502_pkg::*; (
        input  logic  clk,
        input  logic  reset_n,
        input  byte_t instruction_in,
        input  logic  accept,
        output byte_t opcode,
        output sel_t  operand_sel
);

        function automatic sel_t resolve_operand(byte_t op);
                addr_mode_t mode;
                mode = op[4:2];
                case (op)
                        8'hE8, 8'hCA: return SEL_X;     // INX, DEX
                        8'hC8, 8'h88: return SEL_Y;     // INY, DEY
                        default: ;
                endcase
                if (mode == `AM_IMPL)
                        return op[0] ? SEL_IMM : SEL_ACC;
                // LDY #imm and LDX #imm sit in the (zp,X) column
                if (mode == `AM_X_IND)
                        return (op == 8'hA0 || op == 8'hA2) ? SEL_IMM : SEL_MEM;
                return SEL_MEM;
        endfunction

        always_ff @(posedge clk) begin
                if (!reset_n) begin
                        opcode      <= '0;      // BRK, never accepted
                        operand_sel <= SEL_MEM;
                end else if (accept) begin
                        opcode      <= instruction_in;
                        operand_sel <= resolve_operand(instruction_in);
                end
        end

endmodule

// ==== step_sequencer.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Instruction step FSM
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module step_sequencer import dec6502_pkg::*; (
        input  logic       clk,
        input  logic       reset_n,
        input  logic       instruction_ready,
        input  logic       raw_supported,
        input  op_class_t  op_class,
        input  logic       alu_done,
        output logic       accept,
        output seq_state_t state
);

        seq_state_t next_state;

        // Strobes outside IDLE are dropped
        assign accept = (state == ST_IDLE) && instruction_ready && raw_supported;

        always_comb begin
                next_state = state;
                case (state)
                        ST_IDLE: begin
                                if (accept)
                                        next_state = ST_SETUP;
                        end
                        ST_SETUP: begin
                                next_state = (op_class == CLASS_MOVE) ? ST_WRITE : ST_WAIT_ALU;
                        end
                        ST_WAIT_ALU: begin
                                if (alu_done)
                                        next_state = ST_WRITE;
                        end
                        ST_WRITE: begin
                                // Memory write lands before done on RMW
                                next_state = (op_class == CLASS_RMW) ? ST_FINISH : ST_IDLE;
                        end
                        default: begin
                                next_state = ST_IDLE;
                        end
                endcase
        end

        always_ff @(posedge clk) begin
                if (!reset_n)
                        state <= ST_IDLE;
                else
                        state <= next_state;
        end

endmodule

// ==== tb_dec6502.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Self-checking testbench for the decoder, vectors
// read from the tests file
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module tb_dec6502 import dec6502_pkg::*; ();

        localparam int COLS            = 11;
        localparam int MAX_TESTS       = 64;
        localparam int CYCLES_PER_TEST = 20;

        typedef struct packed {
                byte_t      opcode;
                byte_t      status;
                logic [2:0] alu_op;
                logic [2:0] alu0_sel;
                logic [2:0] alu1_sel;
                logic       carry_in;
                logic       update_status;
                logic [4:0] we;
                logic [2:0] wb_sel;
                logic       rmw;
                logic       supported;
        } test_case_t;

        logic  clk;
        logic  reset_n;
        logic  instruction_ready;
        logic  alu_done;
        byte_t instruction_in;
        byte_t status_in;
        ctrl_t ctrl;
        we_t   we;
        sel_t  wb_sel;
        logic  instruction_done;
        logic  busy;

        logic [7:0] vec_mem [0:MAX_TESTS*COLS-1];
        int num_tests;
        int cycle_count = 0;
        int cycle_limit = MAX_TESTS * CYCLES_PER_TEST;

        dec6502_top dut_i (
                .clk               (clk),
                .reset_n           (reset_n),
                .instruction_ready (instruction_ready),
                .instruction_in    (instruction_in),
                .status_in         (status_in),
                .alu_done          (alu_done),
                .ctrl              (ctrl),
                .we                (we),
                .wb_sel            (wb_sel),
                .instruction_done  (instruction_done),
                .busy              (busy)
        );

        initial begin
                clk = 1'b0;
                forever #4 clk = ~clk;
        end

        always @(posedge clk) begin
                cycle_count <= cycle_count + 1;
                if (cycle_count >= cycle_limit) begin
                        $display("Timeout: run still going after %0d clock cycles", cycle_count);
                        $display("=== FAIL ===");
                        $fatal(1, "simulation timed out");
                end
        end

        task automatic report_error(input string msg);
                $display("CHECK FAILED at %0t: %s", $time, msg);
                $display("=== FAIL ===");
                $fatal(1, "stopped at first failing check");
        endtask

        function automatic test_case_t load_case(input int idx);
                test_case_t tc;
                int         b;
                b                = idx * COLS;
                tc.opcode        = vec_mem[b];
                tc.status        = vec_mem[b+1];
                tc.alu_op        = vec_mem[b+2][2:0];
                tc.alu0_sel      = vec_mem[b+3][2:0];
                tc.alu1_sel      = vec_mem[b+4][2:0];
                tc.carry_in      = vec_mem[b+5][0];
                tc.update_status = vec_mem[b+6][0];
                tc.we            = vec_mem[b+7][4:0];
                tc.wb_sel        = vec_mem[b+8][2:0];
                tc.rmw           = vec_mem[b+9][0];
                tc.supported     = vec_mem[b+10][0];
                return tc;
        endfunction

        task automatic check_quiet(input string tag);
                assert (we == '0) else report_error({tag, ": unexpected write enable"});
                assert (!instruction_done) else report_error({tag, ": unexpected done pulse"});
        endtask

        task automatic check_ctrl(input test_case_t tc);
                assert (ctrl.alu_op == tc.alu_op && ctrl.alu0_sel == tc.alu0_sel &&
                        ctrl.alu1_sel == tc.alu1_sel && ctrl.carry_in == tc.carry_in &&
                        ctrl.update_status == tc.update_status)
                else report_error($sformatf(
                        "opcode %02h: ctrl %0d %0d/%0d %0d %0d, expected %0d %0d/%0d %0d %0d",
                        tc.opcode, ctrl.alu_op, ctrl.alu0_sel, ctrl.alu1_sel, ctrl.carry_in,
                        ctrl.update_status, tc.alu_op, tc.alu0_sel, tc.alu1_sel, tc.carry_in,
                        tc.update_status));
        endtask

        task automatic check_write(input test_case_t tc, input logic expect_done);
                assert (we == tc.we && wb_sel == tc.wb_sel)
                else report_error($sformatf("opcode %02h: we %05b wb_sel %0d, expected %05b %0d",
                        tc.opcode, we, wb_sel, tc.we, tc.wb_sel));
                assert (instruction_done == expect_done)
                else report_error($sformatf("opcode %02h: done %0b with the write, expected %0b",
                        tc.opcode, instruction_done, expect_done));
                assert (busy) else report_error($sformatf("opcode %02h: busy low at write",
                        tc.opcode));
        endtask

        task automatic run_case(input test_case_t tc);
                int    delay;
                string tag;
                tag = $sformatf("opcode %02h", tc.opcode);
                @(posedge clk);
                instruction_in    <= tc.opcode;
                status_in         <= tc.status;
                instruction_ready <= 1'b1;
                @(posedge clk);
                if (!tc.supported) begin
                        instruction_ready <= 1'b0;
                        repeat (4) begin
                                @(negedge clk);
                                assert (!busy) else report_error({tag, ": busy for unsupported"});
                                check_quiet(tag);
                        end
                end else begin
                        // Second strobe lands while busy
                        instruction_in <= (tc.opcode == 8'hE8) ? 8'hC8 : 8'hE8;
                        @(negedge clk);
                        assert (busy) else report_error({tag, ": busy did not rise"});
                        @(posedge clk);
                        instruction_ready <= 1'b0;
                        @(negedge clk);
                        check_ctrl(tc);
                        check_quiet(tag);
                        if (tc.alu_op != 3'd0) begin
                                delay = $urandom % 6;
                                repeat (delay) begin
                                        @(posedge clk);
                                        @(negedge clk);
                                        check_ctrl(tc);
                                        check_quiet(tag);
                                end
                                @(posedge clk);
                                alu_done <= 1'b1;
                                @(posedge clk);
                                alu_done <= 1'b0;
                                @(negedge clk);
                                check_quiet(tag);
                        end
                        @(posedge clk);
                        @(negedge clk);
                        check_ctrl(tc);
                        check_write(tc, !tc.rmw);
                        if (tc.rmw) begin
                                @(posedge clk);
                                @(negedge clk);
                                check_ctrl(tc);
                                assert (we == '0 && instruction_done)
                                else report_error({tag, ": done did not follow the memory write"});
                        end
                        @(posedge clk);
                        @(negedge clk);
                        check_quiet(tag);
                        assert (!busy && ctrl.alu_op == ALU_NONE && !ctrl.update_status)
                        else report_error({tag, ": not back to idle after done"});
                        @(posedge clk);
                        @(negedge clk);
                        assert (!busy) else report_error({tag, ": strobe during busy was taken"});
                end
        endtask

        initial begin
                test_case_t tc;
                int         i;
                instruction_ready = 1'b0;
                instruction_in    = '0;
                status_in         = '0;
                alu_done          = 1'b0;
                reset_n           = 1'b0;
                void'($urandom(32'hebe9));
                for (i = 0; i < MAX_TESTS * COLS; i++)
                        vec_mem[i] = 8'hFF;             // FF in the supported column ends the list
                $readmemh("dec6502_tests.txt", vec_mem);
                num_tests = 0;
                while (num_tests < MAX_TESTS && vec_mem[num_tests*COLS + COLS-1] != 8'hFF)
                        num_tests++;
                if (num_tests == 0) begin
                        $display("No test vectors were read from dec6502_tests.txt");
                        $display("=== FAIL ===");
                        $fatal(1, "empty test list");
                end
                cycle_limit = num_tests * CYCLES_PER_TEST;
                repeat (16) @(posedge clk);
                reset_n <= 1'b1;
                @(negedge clk);
                assert (!busy && !instruction_done && we == '0 && ctrl.alu_op == ALU_NONE)
                else report_error("outputs not idle after reset");
                for (i = 0; i < num_tests; i++) begin
                        tc = load_case(i);
                        run_case(tc);
                end
                $display("=== PASS ===");
                $finish;
        end

endmodule
